// File: hw/div_pkg.sv
// ============================================================
// Shared types of the divide unit
// ============================================================

package div_pkg;

	// Operand interpretation for one divide
	// The fourth encoding is never legal and is trapped at the operand stage
	typedef enum logic [1:0] {
		// Dividend and divisor are both plain magnitudes
		div_unsigned        = 2'd0,
		// Dividend and divisor are both two's complement
		div_signed          = 2'd1,
		// Only the dividend carries a sign, the divisor is a magnitude
		div_signed_dividend = 2'd2
	} div_mode_t;

	// States of the divide core FSM
	// Done is reported in commit, fast and finish, and in idle without a load
	typedef enum logic [2:0] {
		// Waiting for a load, results held from the last operation
		st_idle   = 3'd0,
		// One quotient bit resolved per clock
		st_divide = 3'd1,
		// Result registers valid, cache entry written on the way out
		st_commit = 3'd2,
		// Result taken straight from the cache
		st_fast   = 3'd3,
		// Last cycle before the core accepts a new load
		st_finish = 3'd4
	} div_state_t;

	// The cache key is the raw dividend, the effective divisor and the mode
	// A hit therefore needs all three to match an entry

endpackage

// File: hw/div_op_if.sv
// ============================================================
// Prepared operation bus
// ============================================================

interface div_op_if import div_pkg::*; #(
	parameter int WID = 32
) ();

	// Strobe for an operation the core has accepted
	logic load;
	// Key fields as seen by the cache
	logic [WID-1:0] dividend;
	logic [WID-1:0] divisor;
	div_mode_t mode;
	// Datapath inputs for the shift-subtract core
	logic [WID-1:0] dividend_mag;
	logic [WID-1:0] divisor_mag;
	logic neg_result;
	logic div_zero;

	// Operand preparation drives the whole bus
	modport prep (output load, dividend, divisor, mode,
		dividend_mag, divisor_mag, neg_result, div_zero);

	// The core needs every field
	modport core (input load, dividend, divisor, mode,
		dividend_mag, divisor_mag, neg_result, div_zero);

	// The cache only looks at the key and the load strobe
	modport cache (input load, dividend, divisor, mode);

endinterface

// File: hw/div_operand_prep.sv
module div_operand_prep import div_pkg::*; #(
	parameter int WID = 32
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           ld,
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] b,
	input  logic [WID-1:0] imm,
	input  logic           use_imm,
	input  div_mode_t      mode,
	div_op_if.prep         op
);

	// Effective divisor and the sign bits of both operands
	logic [WID-1:0] divisor;
	logic a_neg;
	logic d_neg;

	// ============================================================
	// Divisor select
	// ============================================================

	// The immediate form replaces the register divisor entirely
	assign divisor = use_imm ? imm : b;
	assign a_neg = a[WID-1];
	assign d_neg = divisor[WID-1];

	// Key fields pass through untouched so that the cache sees the
	// operation as the pipeline issued it
	assign op.load = ld;
	assign op.dividend = a;
	assign op.divisor = divisor;
	assign op.mode = mode;

	// A zero divisor is flagged on the raw bits, the sign never matters here
	assign op.div_zero = (divisor == '0);

	// ============================================================
	// Magnitudes and result sign
	// ============================================================

	always_comb begin
		case (mode)
			div_signed: begin
				// Both operands folded to magnitudes
				op.dividend_mag = a_neg ? -a : a;
				op.divisor_mag = d_neg ? -divisor : divisor;
				op.neg_result = a_neg ^ d_neg;
			end
			div_signed_dividend: begin
				// Divisor is already a magnitude in this mode
				op.dividend_mag = a_neg ? -a : a;
				op.divisor_mag = divisor;
				op.neg_result = a_neg;
			end
			default: begin
				op.dividend_mag = a;
				op.divisor_mag = divisor;
				op.neg_result = 1'b0;
			end
		endcase
	end

	// The issue stage must never hand over the spare mode encoding
	assert property (@(posedge clk) disable iff (rst)
		ld |-> mode inside {div_unsigned, div_signed, div_signed_dividend});

endmodule

// File: hw/div_core.sv
module div_core import div_pkg::*; #(
	parameter int WID = 32
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           abort,
	div_op_if.core         op,
	input  logic           hit,
	input  logic [WID-1:0] hit_quotient,
	input  logic [WID-1:0] hit_remainder,
	output logic [WID-1:0] quotient,
	output logic [WID-1:0] remainder,
	output logic           div_by_zero,
	output logic           done,
	output logic           idle,
	output logic           commit
);

	// Iteration counter wide enough to hold WID+1
	localparam int CNT_W = $clog2(WID + 2);

	div_state_t state;
	logic [CNT_W-1:0] cnt;
	logic cnt_done;
	// Set when the running divide was cut short
	logic aborted;

	// Shift-subtract datapath
	// q starts as the dividend magnitude and fills up with quotient bits
	logic [WID-1:0] q;
	logic [WID-1:0] bb;
	logic [WID:0] r;
	logic neg;
	logic [WID:0] diff;
	logic fits;
	logic [WID-1:0] r_next;

	assign cnt_done = (cnt == '0);

	// The divisor fits when the partial remainder is at least as large
	// The difference is then always below the divisor and fits WID bits
	assign diff = r - {1'b0, bb};
	assign fits = ({1'b0, bb} <= r);
	assign r_next = fits ? diff[WID-1:0] : r[WID-1:0];

	assign idle = (state == st_idle);
	assign done = (state == st_commit) || (state == st_fast) ||
		(state == st_finish) || (state == st_idle && !op.load);

	// A cut-short divide holds a partial result that must never be cached
	assign commit = (state == st_commit) && !aborted;

	// ============================================================
	// Datapath
	// ============================================================

	always_ff @(posedge clk) begin
		if (state == st_idle && op.load) begin
			q <= op.dividend_mag;
			bb <= op.divisor_mag;
			r <= '0;
			neg <= op.neg_result;
		end else if (state == st_divide && !cnt_done) begin
			// One quotient bit in, one dividend bit over into the remainder
			q <= {q[WID-2:0], fits};
			r <= {r_next, q[WID-1]};
		end
	end

	// ============================================================
	// Control FSM and result registers
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			cnt <= '0;
			aborted <= 1'b0;
			div_by_zero <= 1'b0;
			quotient <= '0;
			remainder <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (op.load) begin
						div_by_zero <= op.div_zero;
						aborted <= 1'b0;
						if (hit) begin
							quotient <= hit_quotient;
							remainder <= hit_remainder;
							state <= st_fast;
						end else begin
							// The first pass only primes the remainder, so WID+1 passes
							cnt <= CNT_W'(WID + 1);
							state <= st_divide;
						end
					end
				end
				st_divide: begin
					if (abort) begin
						cnt <= '0;
						aborted <= 1'b1;
					end else if (!cnt_done) begin
						cnt <= cnt - CNT_W'(1);
					end else begin
						// Remainder sits one place up because of the priming pass
						quotient <= neg ? -q : q;
						remainder <= neg ? -r[WID:1] : r[WID:1];
						state <= st_commit;
					end
				end
				st_commit: state <= st_finish;
				st_fast: state <= st_finish;
				default: state <= st_idle;
			endcase
		end
	end

	// A miss that runs its whole divide without an abort raises done
	// on the commit edge, WID+3 edges after the load
	assert property (@(posedge clk) disable iff (rst)
		(op.load && !hit) ##1 (!abort) [*WID+2] |=> done);

endmodule

// File: hw/div_result_cache.sv
module div_result_cache import div_pkg::*; #(
	parameter int WID = 32,
	parameter int CACHE_DEPTH = 8
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           cache_enable,
	input  logic           flush,
	div_op_if.cache        op,
	input  logic           commit,
	input  logic [WID-1:0] quotient,
	input  logic [WID-1:0] remainder,
	output logic           hit,
	output logic [WID-1:0] hit_quotient,
	output logic [WID-1:0] hit_remainder,
	output logic           hit_pulse,
	output logic           miss_pulse
);

	// Entry storage, index 0 holds the newest result
	logic [WID-1:0] ent_dividend [CACHE_DEPTH];
	logic [WID-1:0] ent_divisor [CACHE_DEPTH];
	div_mode_t ent_mode [CACHE_DEPTH];
	logic [WID-1:0] ent_quotient [CACHE_DEPTH];
	logic [WID-1:0] ent_remainder [CACHE_DEPTH];
	logic [CACHE_DEPTH-1:0] ent_valid;

	// Key of the operation in flight, captured at load for the later write
	logic [WID-1:0] key_dividend;
	logic [WID-1:0] key_divisor;
	div_mode_t key_mode;

	logic found;

	// ============================================================
	// Lookup
	// ============================================================

	// Scan from the oldest end so that the newest matching entry wins
	always_comb begin
		found = 1'b0;
		hit_quotient = '0;
		hit_remainder = '0;
		for (int i = CACHE_DEPTH - 1; i >= 0; i--) begin
			if (ent_valid[i] && ent_dividend[i] == op.dividend &&
					ent_divisor[i] == op.divisor && ent_mode[i] == op.mode) begin
				found = 1'b1;
				hit_quotient = ent_quotient[i];
				hit_remainder = ent_remainder[i];
			end
		end
	end

	// With the cache switched off every load goes the long way
	assign hit = found && cache_enable;
	assign hit_pulse = op.load && hit;
	assign miss_pulse = op.load && !hit;

	// ============================================================
	// Write
	// ============================================================

	always_ff @(posedge clk) begin
		if (op.load) begin
			key_dividend <= op.dividend;
			key_divisor <= op.divisor;
			key_mode <= op.mode;
		end
	end

	// Every entry moves one place down and the oldest drops off the end
	always_ff @(posedge clk) begin
		if (commit) begin
			for (int i = CACHE_DEPTH - 1; i > 0; i--) begin
				ent_dividend[i] <= ent_dividend[i-1];
				ent_divisor[i] <= ent_divisor[i-1];
				ent_mode[i] <= ent_mode[i-1];
				ent_quotient[i] <= ent_quotient[i-1];
				ent_remainder[i] <= ent_remainder[i-1];
			end
			ent_dividend[0] <= key_dividend;
			ent_divisor[0] <= key_divisor;
			ent_mode[0] <= key_mode;
			ent_quotient[0] <= quotient;
			ent_remainder[0] <= remainder;
		end
	end

	// Flush takes priority over a write in the same cycle
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ent_valid <= '0;
		end else if (commit) begin
			ent_valid <= {ent_valid[CACHE_DEPTH-2:0], 1'b1};
		end
	end

	// The core writes back only after its divide, never while a new load looks up
	assert property (@(posedge clk) disable iff (rst)
		commit |-> !op.load);

endmodule

// File: hw/div_cache_ctrl.sv
module div_cache_ctrl (
	input  logic        clk,
	input  logic        rst,
	input  logic        cache_en,
	input  logic        cache_flush,
	input  logic        hit_pulse,
	input  logic        miss_pulse,
	output logic        cache_enable,
	output logic        flush,
	output logic [15:0] hit_count,
	output logic [15:0] miss_count
);

	// Counters stop at this value instead of wrapping
	localparam logic [15:0] CNT_MAX = 16'hffff;

	// Previous level of the flush request for edge detection
	logic flush_req_d;

	// ============================================================
	// Configuration
	// ============================================================

	// A held flush request still produces a single flush cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			cache_enable <= 1'b0;
			flush_req_d <= 1'b0;
			flush <= 1'b0;
		end else begin
			cache_enable <= cache_en;
			flush_req_d <= cache_flush;
			flush <= cache_flush && !flush_req_d;
		end
	end

	// ============================================================
	// Statistics
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			hit_count <= '0;
			miss_count <= '0;
		end else begin
			if (hit_pulse && hit_count != CNT_MAX)
				hit_count <= hit_count + 16'd1;
			if (miss_pulse && miss_count != CNT_MAX)
				miss_count <= miss_count + 16'd1;
		end
	end

endmodule

// File: hw/div_unit.sv
module div_unit import div_pkg::*; #(
	parameter int WID = 32,
	parameter int CACHE_DEPTH = 8
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           ld,
	input  logic           abort,
	input  div_mode_t      mode,
	input  logic           use_imm,
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] b,
	input  logic [WID-1:0] imm,
	output logic [WID-1:0] quotient,
	output logic [WID-1:0] remainder,
	output logic           div_by_zero,
	output logic           done,
	output logic           idle,
	input  logic           cache_en,
	input  logic           cache_flush,
	output logic [15:0]    hit_count,
	output logic [15:0]    miss_count
);

	// Prepared operation shared by core and cache
	div_op_if #(.WID(WID)) op_bus ();

	// Cache to core
	logic hit;
	logic [WID-1:0] hit_quotient;
	logic [WID-1:0] hit_remainder;
	// Core to cache
	logic commit;
	// Cache and control block
	logic hit_pulse;
	logic miss_pulse;
	logic cache_enable;
	logic flush;
	// A load while busy is dropped here and never reaches core or counters
	logic ld_accept;

	assign ld_accept = ld & idle;

	div_operand_prep #(.WID(WID)) u_prep (
		.clk(clk), .rst(rst), .ld(ld_accept), .a(a), .b(b), .imm(imm),
		.use_imm(use_imm), .mode(mode), .op(op_bus.prep)
	);

	div_core #(.WID(WID)) u_core (
		.clk(clk), .rst(rst), .abort(abort), .op(op_bus.core),
		.hit(hit), .hit_quotient(hit_quotient), .hit_remainder(hit_remainder),
		.quotient(quotient), .remainder(remainder), .div_by_zero(div_by_zero),
		.done(done), .idle(idle), .commit(commit)
	);

	div_result_cache #(.WID(WID), .CACHE_DEPTH(CACHE_DEPTH)) u_cache (
		.clk(clk), .rst(rst), .cache_enable(cache_enable), .flush(flush),
		.op(op_bus.cache), .commit(commit), .quotient(quotient),
		.remainder(remainder), .hit(hit), .hit_quotient(hit_quotient),
		.hit_remainder(hit_remainder), .hit_pulse(hit_pulse), .miss_pulse(miss_pulse)
	);

	div_cache_ctrl u_ctrl (
		.clk(clk), .rst(rst), .cache_en(cache_en), .cache_flush(cache_flush),
		.hit_pulse(hit_pulse), .miss_pulse(miss_pulse), .cache_enable(cache_enable),
		.flush(flush), .hit_count(hit_count), .miss_count(miss_count)
	);

endmodule

// File: test/div_unit_checker.sv
module div_unit_checker import div_pkg::*; #(
	parameter int WID = 32
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             ld,
	input  logic             abort,
	input  div_mode_t        mode,
	input  logic             use_imm,
	input  logic [WID-1:0]   a,
	input  logic [WID-1:0]   b,
	input  logic [WID-1:0]   imm,
	input  logic [WID-1:0]   quotient,
	input  logic [WID-1:0]   remainder,
	input  logic             div_by_zero,
	input  logic             done,
	input  logic             idle,
	input  logic             cache_flush,
	input  logic [15:0]      hit_count,
	input  logic [15:0]      miss_count,
	input  logic [8*16-1:0]  test_name,
	input  logic             exp_hit,
	output int               checks,
	output int               errors
);

	// Operation in flight, captured on the edge that accepted the load
	logic busy;
	logic aborted;
	int lat;
	int abort_lat;
	logic [8*16-1:0] cur_name;
	logic cur_hit;
	logic [WID-1:0] exp_q;
	logic [WID-1:0] exp_r;
	logic exp_dz;
	logic [15:0] hits_before;
	logic [15:0] misses_before;
	// Copies taken on the falling edge where every DUT output is settled
	logic idle_n;
	logic [15:0] hit_n;
	logic [15:0] miss_n;
	// Flush request history, bit 1 marks the cycle the counters must read zero
	logic flush_prev;
	logic [1:0] flush_age;

	initial begin
		checks = 0;
		errors = 0;
		busy = 1'b0;
		aborted = 1'b0;
		idle_n = 1'b0;
		hit_n = '0;
		miss_n = '0;
		flush_prev = 1'b0;
		flush_age = '0;
	end

	task automatic compare(input logic [8*16-1:0] name, input string what,
		input logic [WID-1:0] expv, input logic [WID-1:0] act);
		checks++;
		if (expv !== act) begin
			errors++;
			$display("MISMATCH %0s %0s expected %0h actual %0h", name, what, expv, act);
		end
	endtask

	// ============================================================
	// Reference model of one divide
	// ============================================================

	// Magnitude division, then the sign of the result goes on both outputs
	task automatic predict(input logic [WID-1:0] xa, input logic [WID-1:0] xd,
		input div_mode_t m, output logic [WID-1:0] q, output logic [WID-1:0] r,
		output logic dz);
		logic sa;
		logic sd;
		logic [WID-1:0] am;
		logic [WID-1:0] dm;
		logic [WID-1:0] qm;
		logic [WID-1:0] rm;
		// The dividend is signed in both signed modes, the divisor only in one
		sa = (m != div_unsigned) && xa[WID-1];
		sd = (m == div_signed) && xd[WID-1];
		am = sa ? -xa : xa;
		dm = sd ? -xd : xd;
		dz = (xd == '0);
		if (dm == '0) begin
			// Zero divisor gives all ones and leaves the dividend as remainder
			qm = '1;
			rm = am;
		end else begin
			qm = am / dm;
			rm = am % dm;
		end
		q = (sa ^ sd) ? -qm : qm;
		r = (sa ^ sd) ? -rm : rm;
	endtask

	// Outputs right after reset
	initial begin
		@(negedge rst);
		compare("reset", "quotient", '0, quotient);
		compare("reset", "remainder", '0, remainder);
		compare("reset", "div_by_zero", '0, div_by_zero);
		compare("reset", "done", 1, done);
		compare("reset", "idle", 1, idle);
		compare("reset", "hit_count", '0, hit_count);
		compare("reset", "miss_count", '0, miss_count);
	end

	// ============================================================
	// Input side, sampled on the rising edge
	// ============================================================

	always @(posedge clk) begin
		if (rst) begin
			busy = 1'b0;
		end else if (ld && idle_n) begin
			busy = 1'b1;
			aborted = 1'b0;
			lat = 1;
			cur_name = test_name;
			cur_hit = exp_hit;
			hits_before = hit_n;
			misses_before = miss_n;
			predict(a, use_imm ? imm : b, mode, exp_q, exp_r, exp_dz);
		end else if (busy) begin
			lat++;
			if (abort && !aborted) begin
				aborted = 1'b1;
				abort_lat = 0;
			end else if (aborted) begin
				abort_lat++;
			end
		end
		flush_age = {flush_age[0], cache_flush && !flush_prev};
		flush_prev = cache_flush;
	end

	// ============================================================
	// Output side, compared on the falling edge
	// ============================================================

	always @(negedge clk) begin
		idle_n = idle;
		hit_n = hit_count;
		miss_n = miss_count;
		if (busy && aborted) begin
			// A cut-short divide only has to give the unit back in time
			if (idle) begin
				busy = 1'b0;
				checks++;
			end else if (abort_lat > WID + 4) begin
				busy = 1'b0;
				errors++;
				$display("ERROR %0s: idle did not return within %0d cycles after abort",
					cur_name, WID + 4);
			end
		end else if (busy && done) begin
			busy = 1'b0;
			compare(cur_name, "quotient", exp_q, quotient);
			compare(cur_name, "remainder", exp_r, remainder);
			compare(cur_name, "div_by_zero", exp_dz, div_by_zero);
			// Hit answers on the first edge, a miss after load, WID+1 passes and commit
			compare(cur_name, "latency", cur_hit ? 1 : WID + 3, lat);
			compare(cur_name, "hit_count", hits_before + cur_hit, hit_count);
			compare(cur_name, "miss_count", misses_before + !cur_hit, miss_count);
		end
		if (flush_age[1]) begin
			compare(test_name, "flushed hits", '0, hit_count);
			compare(test_name, "flushed misses", '0, miss_count);
		end
	end

endmodule

// File: test/div_unit_tb.sv
module div_unit_tb import div_pkg::*; ();

	localparam int WID = 32;
	localparam int PERIOD = 4;
	localparam int N_RANDOM = 40;
	localparam logic [31:0] SEED = 32'd29;

	// One row of the stimulus table
	// disturb 1 pulses ld while busy, disturb 2 aborts the divide
	typedef struct packed {
		logic [8*16-1:0] name;
		logic [WID-1:0] a;
		logic [WID-1:0] b;
		logic [WID-1:0] imm;
		logic use_imm;
		div_mode_t mode;
		logic cache_en;
		logic flush;
		logic [1:0] disturb;
		logic exp_hit;
	} entry_t;

	logic clk;
	logic rst;
	logic ld;
	logic abort;
	div_mode_t mode;
	logic use_imm;
	logic [WID-1:0] a;
	logic [WID-1:0] b;
	logic [WID-1:0] imm;
	logic [WID-1:0] quotient;
	logic [WID-1:0] remainder;
	logic div_by_zero;
	logic done;
	logic idle;
	logic cache_en;
	logic cache_flush;
	logic [15:0] hit_count;
	logic [15:0] miss_count;
	logic [8*16-1:0] test_name;
	logic exp_hit;
	int checks;
	int errors;
	entry_t stim[$];
	logic [31:0] seed;
	logic stim_ready;
	int limit_cycles;

	div_unit #(.WID(WID), .CACHE_DEPTH(8)) dut0 (
		.clk(clk), .rst(rst), .ld(ld), .abort(abort), .mode(mode), .use_imm(use_imm),
		.a(a), .b(b), .imm(imm), .quotient(quotient), .remainder(remainder),
		.div_by_zero(div_by_zero), .done(done), .idle(idle), .cache_en(cache_en),
		.cache_flush(cache_flush), .hit_count(hit_count), .miss_count(miss_count)
	);

	div_unit_checker #(.WID(WID)) chk0 (
		.clk(clk), .rst(rst), .ld(ld), .abort(abort), .mode(mode), .use_imm(use_imm),
		.a(a), .b(b), .imm(imm), .quotient(quotient), .remainder(remainder),
		.div_by_zero(div_by_zero), .done(done), .idle(idle), .cache_flush(cache_flush),
		.hit_count(hit_count), .miss_count(miss_count), .test_name(test_name),
		.exp_hit(exp_hit), .checks(checks), .errors(errors)
	);

	always #(PERIOD / 2) clk = ~clk;

	// LCG step, halves swapped so the low bits are not the weak ones
	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return {seed[15:0], seed[31:16]};
	endfunction

	task automatic add_entry(input logic [8*16-1:0] name, input logic [WID-1:0] ea,
		input logic [WID-1:0] eb, input logic [WID-1:0] eimm, input logic euse,
		input div_mode_t emode, input logic ecache, input logic eflush,
		input logic [1:0] edisturb, input logic ehit);
		entry_t e;
		e = '{name, ea, eb, eimm, euse, emode, ecache, eflush, edisturb, ehit};
		stim.push_back(e);
	endtask

	// ============================================================
	// Directed table
	// ============================================================

	task automatic build_table();
		add_entry("u_basic", 100, 7, 0, 0, div_unsigned, 0, 0, 0, 0);
		add_entry("u_topbit", 32'hf000_0000, 3, 0, 0, div_unsigned, 0, 0, 0, 0);
		add_entry("u_both_top", 32'hffff_ffff, 32'h8000_0001, 0, 0, div_unsigned, 0, 0, 0, 0);
		add_entry("s_neg_pos", -100, 7, 0, 0, div_signed, 0, 0, 0, 0);
		add_entry("s_pos_neg", 100, -7, 0, 0, div_signed, 0, 0, 0, 0);
		add_entry("s_neg_neg", -100, -7, 0, 0, div_signed, 0, 0, 0, 0);
		add_entry("s_min", 32'h8000_0000, -1, 0, 0, div_signed, 0, 0, 0, 0);
		add_entry("sd_neg", -100, 7, 0, 0, div_signed_dividend, 0, 0, 0, 0);
		add_entry("sd_bigdiv", -100, 32'hffff_fff0, 0, 0, div_signed_dividend, 0, 0, 0, 0);
		add_entry("u_zero", 55, 0, 0, 0, div_unsigned, 0, 0, 0, 0);
		add_entry("s_zero", -55, 0, 0, 0, div_signed, 0, 0, 0, 0);
		// Same b, two immediates, then repeats with the cache on and off
		add_entry("imm_a", 1000, 3, 10, 1, div_unsigned, 1, 0, 0, 0);
		add_entry("imm_b", 1000, 3, 7, 1, div_unsigned, 1, 0, 0, 0);
		add_entry("hit_repeat", 1000, 3, 7, 1, div_unsigned, 1, 0, 0, 1);
		add_entry("hit_off", 1000, 3, 7, 1, div_unsigned, 0, 0, 0, 0);
		add_entry("flush_miss", 1000, 3, 7, 1, div_unsigned, 1, 1, 0, 0);
		// Eight more distinct results push flush_miss out of the cache
		for (int i = 1; i <= 8; i++)
			add_entry({"evict_", 8'(48 + i)}, 5000 + 13 * i, 7 + i, 0, 0, div_signed,
				1, 0, 0, 0);
		add_entry("evict_hit", 5013, 8, 0, 0, div_signed, 1, 0, 0, 1);
		add_entry("evict_miss", 1000, 3, 7, 1, div_unsigned, 1, 0, 0, 0);
		add_entry("busy_ld", 777777, 111, 0, 0, div_unsigned, 1, 0, 1, 0);
		add_entry("abort_op", 123456789, 10, 0, 0, div_signed, 1, 0, 2, 0);
		// The aborted result was never written, so only the second repeat hits
		add_entry("post_abort", 123456789, 10, 0, 0, div_signed, 1, 0, 0, 0);
		add_entry("post_abort_hit", 123456789, 10, 0, 0, div_signed, 1, 0, 0, 1);
	endtask

	// Every fourth random row repeats one of the three rows before it
	task automatic add_random_entries();
		entry_t e;
		int base;
		int src;
		int shift;
		base = stim.size();
		for (int i = 0; i < N_RANDOM; i++) begin
			if (i % 4 == 3) begin
				src = base + i - 1 - int'(next_random() % 3);
				e = stim[src];
				e.cache_en = (next_random() % 4 != 0);
				e.exp_hit = e.cache_en;
			end else begin
				e.a = next_random();
				shift = int'(next_random() % 32);
				e.b = next_random() >> shift;
				e.imm = next_random() % 4096;
				e.use_imm = (next_random() % 4 == 0);
				e.mode = div_mode_t'(next_random() % 3);
				e.cache_en = (next_random() % 4 != 0);
				e.exp_hit = 1'b0;
			end
			e.name = {"rand_", 8'(48 + i / 10), 8'(48 + i % 10)};
			e.flush = 1'b0;
			e.disturb = 2'd0;
			stim.push_back(e);
		end
	endtask

	// ============================================================
	// Driving one row
	// ============================================================

	task automatic pulse_flush();
		cache_flush = 1'b1;
		@(negedge clk);
		cache_flush = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic run_entry(input entry_t e);
		test_name = e.name;
		exp_hit = e.exp_hit;
		if (e.flush)
			pulse_flush();
		// The enable is registered, so it must settle a cycle before the load
		cache_en = e.cache_en;
		@(negedge clk);
		while (!idle)
			@(negedge clk);
		a = e.a;
		b = e.b;
		imm = e.imm;
		use_imm = e.use_imm;
		mode = e.mode;
		ld = 1'b1;
		@(negedge clk);
		ld = 1'b0;
		if (e.disturb == 2'd1) begin
			repeat (4) @(negedge clk);
			ld = 1'b1;
			a = ~e.a;
			@(negedge clk);
			ld = 1'b0;
			a = e.a;
		end else if (e.disturb == 2'd2) begin
			repeat (4) @(negedge clk);
			abort = 1'b1;
			@(negedge clk);
			abort = 1'b0;
		end
		if (e.disturb == 2'd2) begin
			while (!idle)
				@(negedge clk);
		end else begin
			while (!done)
				@(negedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		ld = 1'b0;
		abort = 1'b0;
		mode = div_unsigned;
		use_imm = 1'b0;
		a = '0;
		b = '0;
		imm = '0;
		cache_en = 1'b0;
		cache_flush = 1'b0;
		test_name = "reset";
		exp_hit = 1'b0;
		seed = SEED;
		stim_ready = 1'b0;
		build_table();
		add_random_entries();
		stim_ready = 1'b1;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		foreach (stim[i])
			run_entry(stim[i]);
		repeat (4) @(negedge clk);
		$display("Closing report: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Budget of WID+10 cycles per row on top of the reset time
	initial begin
		wait (stim_ready);
		limit_cycles = 10 + stim.size() * (WID + 10);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: the run did not complete within %0d cycles", limit_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: div_unit.f
hw/div_pkg.sv
hw/div_op_if.sv
hw/div_operand_prep.sv
hw/div_core.sv
hw/div_result_cache.sv
hw/div_cache_ctrl.sv
hw/div_unit.sv
test/div_unit_checker.sv
test/div_unit_tb.sv
